// File: verilog/cpu_isa_pkg.sv
/*
 * Instruction-set definitions for the 32-bit pipelined CPU.
 * Word and register widths, instruction field positions,
 * opcodes and the ALU, memory and result-select encodings.
 */
`default_nettype none

package cpu_isa_pkg;

	// ----------------------------------------
	// widths
	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int gpr_num    = 32;   // r0 hardwired to zero
	localparam int opcode_w   = 6;
	localparam int imm_w      = 16;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [imm_w-1:0]      imm_t;

	// ----------------------------------------
	// instruction field positions
	localparam int opcode_msb = 31;
	localparam int opcode_lsb = 26;
	localparam int ra_msb     = 25;
	localparam int ra_lsb     = 21;
	localparam int rb_msb     = 20;
	localparam int rb_lsb     = 16;
	localparam int rc_msb     = 15;
	localparam int rc_lsb     = 11;
	localparam int imm_msb    = 15;
	localparam int imm_lsb    = 0;

	localparam reg_addr_t gpr_link_addr = 5'd31;   // call writes its return address here
	localparam word_t     pc_step       = 32'd4;   // one instruction

	// ----------------------------------------
	// encodings, nop is zero everywhere
	typedef enum logic [opcode_w-1:0] {
		op_nop   = 6'h00,
		op_andr  = 6'h01, op_andi = 6'h02,
		op_orr   = 6'h03, op_ori  = 6'h04,
		op_xorr  = 6'h05, op_xori = 6'h06,
		op_addr  = 6'h07, op_addi = 6'h08,
		op_subr  = 6'h09,
		op_shrlr = 6'h0a, op_shllr = 6'h0b,
		op_ldw   = 6'h10, op_stw  = 6'h11,
		op_call  = 6'h20
	} opcode_t;

	typedef enum logic [3:0] {
		alu_nop, alu_and, alu_or, alu_xor, alu_add, alu_sub, alu_shrl, alu_shll
	} alu_op_t;

	typedef enum logic [1:0] {mem_nop, mem_ldw, mem_stw} mem_op_t;

	typedef enum logic {ex_sel_alu, ex_sel_link} ex_out_sel_t;   // link picks gpr_wr_data

endpackage

`default_nettype wire

// File: verilog/cpu_pipe_pkg.sv
/*
 * Pipeline bus definitions. The ID/EX bus carried from decode
 * to execute, its bubble value, and the write-back port.
 */
`default_nettype none

package cpu_pipe_pkg;

	// ----------------------------------------
	// decode -> execute
	typedef struct packed {
		cpu_isa_pkg::alu_op_t     alu_op;
		cpu_isa_pkg::word_t       alu_in_0;
		cpu_isa_pkg::word_t       alu_in_1;
		cpu_isa_pkg::mem_op_t     mem_op;
		cpu_isa_pkg::word_t       mem_wr_data;   // store data, always rb
		cpu_isa_pkg::reg_addr_t   dst_addr;
		logic                     gpr_we;
		cpu_isa_pkg::ex_out_sel_t gpr_mux_ex;
		logic                     gpr_mux_mem;   // 1 takes load data in mem stage
		cpu_isa_pkg::word_t       gpr_wr_data;   // link value pc+4
	} id_ex_bus_t;

	// all-zero bus, every control at its nop encoding
	localparam id_ex_bus_t id_ex_bubble = '0;

	// ----------------------------------------
	// write-back port into the register file
	typedef struct packed {
		logic                   en;
		cpu_isa_pkg::reg_addr_t addr;
		cpu_isa_pkg::word_t     data;
	} wb_t;

endpackage

`default_nettype wire

// File: verilog/gpr_file.sv
/*
 * General-purpose register file, 32 x 32 bits.
 * Two combinational read ports, one write-back port written at the
 * clock edge, same-cycle write-back forwarding, r0 reads zero.
 */
`timescale 1ns/100ps
`default_nettype none

module gpr_file (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire cpu_isa_pkg::reg_addr_t ra_addr,
	input  wire cpu_isa_pkg::reg_addr_t rb_addr,
	output cpu_isa_pkg::word_t          ra_data,
	output cpu_isa_pkg::word_t          rb_data,
	input  wire cpu_pipe_pkg::wb_t      wb
);

	cpu_isa_pkg::word_t regs [1:cpu_isa_pkg::gpr_num-1];   // no storage for r0

	logic wb_hit;   // write-back that actually lands
	assign wb_hit = wb.en && (wb.addr != '0);

	// one read port: zero, forwarded write-back, or stored value
	function automatic cpu_isa_pkg::word_t read_port(input cpu_isa_pkg::reg_addr_t addr);
		cpu_isa_pkg::word_t data;
		if (addr == '0)
			data = '0;
		else if (wb_hit && (wb.addr == addr))
			data = wb.data;   // bypass same-cycle write
		else
			data = regs[addr];
		return data;
	endfunction

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
	end

	// ----------------------------------------
	// write port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < cpu_isa_pkg::gpr_num; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_hit) begin
			regs[wb.addr] <= wb.data;   // writes to r0 dropped by wb_hit
		end
	end

endmodule

`default_nettype wire

// File: verilog/id_decoder.sv
/*
 * Instruction decoder. Splits the instruction word, addresses the
 * register file and builds the ID/EX bus: ALU op and inputs, memory
 * op, store data, destination, write enable and result selects.
 */
`timescale 1ns/100ps
`default_nettype none

module id_decoder (
	input  wire cpu_isa_pkg::word_t     insn,
	input  wire cpu_isa_pkg::word_t     pc,
	output cpu_isa_pkg::reg_addr_t      ra_addr,
	output cpu_isa_pkg::reg_addr_t      rb_addr,
	input  wire cpu_isa_pkg::word_t     ra_data,
	input  wire cpu_isa_pkg::word_t     rb_data,
	output cpu_pipe_pkg::id_ex_bus_t    bus
);

	// ----------------------------------------
	// field split
	cpu_isa_pkg::opcode_t   opcode;
	cpu_isa_pkg::reg_addr_t rc_addr;
	cpu_isa_pkg::imm_t      imm;
	cpu_isa_pkg::word_t     imm_zext;   // logic ops
	cpu_isa_pkg::word_t     imm_sext;   // addi, address offsets
	cpu_isa_pkg::word_t     link_pc;    // return address

	assign opcode  = cpu_isa_pkg::opcode_t'(
		insn[cpu_isa_pkg::opcode_msb:cpu_isa_pkg::opcode_lsb]);   // undefined codes hit default
	assign ra_addr = insn[cpu_isa_pkg::ra_msb:cpu_isa_pkg::ra_lsb];
	assign rb_addr = insn[cpu_isa_pkg::rb_msb:cpu_isa_pkg::rb_lsb];
	assign rc_addr = insn[cpu_isa_pkg::rc_msb:cpu_isa_pkg::rc_lsb];
	assign imm     = insn[cpu_isa_pkg::imm_msb:cpu_isa_pkg::imm_lsb];

	assign imm_zext = {{(cpu_isa_pkg::word_w - cpu_isa_pkg::imm_w){1'b0}}, imm};
	assign imm_sext = {{(cpu_isa_pkg::word_w - cpu_isa_pkg::imm_w){imm[cpu_isa_pkg::imm_w-1]}},
		imm};
	assign link_pc  = pc + cpu_isa_pkg::pc_step;

	// ----------------------------------------
	// decode table
	always_comb begin
		// values shared by every defined op, selects decide use
		bus             = cpu_pipe_pkg::id_ex_bubble;
		bus.alu_in_0    = ra_data;
		bus.alu_in_1    = rb_data;
		bus.mem_wr_data = rb_data;
		bus.gpr_wr_data = link_pc;

		case (opcode)
			// register-register, result to rc
			cpu_isa_pkg::op_andr: begin
				bus.alu_op   = cpu_isa_pkg::alu_and;
				bus.dst_addr = rc_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_orr: begin
				bus.alu_op   = cpu_isa_pkg::alu_or;
				bus.dst_addr = rc_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_xorr: begin
				bus.alu_op   = cpu_isa_pkg::alu_xor;
				bus.dst_addr = rc_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_addr: begin
				bus.alu_op   = cpu_isa_pkg::alu_add;
				bus.dst_addr = rc_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_subr: begin
				bus.alu_op   = cpu_isa_pkg::alu_sub;
				bus.dst_addr = rc_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_shrlr: begin
				bus.alu_op   = cpu_isa_pkg::alu_shrl;
				bus.dst_addr = rc_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_shllr: begin
				bus.alu_op   = cpu_isa_pkg::alu_shll;
				bus.dst_addr = rc_addr;
				bus.gpr_we   = 1'b1;
			end
			// immediate forms, result to rb
			cpu_isa_pkg::op_andi: begin
				bus.alu_op   = cpu_isa_pkg::alu_and;
				bus.alu_in_1 = imm_zext;
				bus.dst_addr = rb_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_ori: begin
				bus.alu_op   = cpu_isa_pkg::alu_or;
				bus.alu_in_1 = imm_zext;
				bus.dst_addr = rb_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_xori: begin
				bus.alu_op   = cpu_isa_pkg::alu_xor;
				bus.alu_in_1 = imm_zext;
				bus.dst_addr = rb_addr;
				bus.gpr_we   = 1'b1;
			end
			cpu_isa_pkg::op_addi: begin
				bus.alu_op   = cpu_isa_pkg::alu_add;
				bus.alu_in_1 = imm_sext;   // signed offset
				bus.dst_addr = rb_addr;
				bus.gpr_we   = 1'b1;
			end
			// memory, address is ra + offset
			cpu_isa_pkg::op_ldw: begin
				bus.alu_op      = cpu_isa_pkg::alu_add;
				bus.alu_in_1    = imm_sext;
				bus.mem_op      = cpu_isa_pkg::mem_ldw;
				bus.gpr_mux_mem = 1'b1;    // load data to rb
				bus.dst_addr    = rb_addr;
				bus.gpr_we      = 1'b1;
			end
			cpu_isa_pkg::op_stw: begin
				bus.alu_op   = cpu_isa_pkg::alu_add;
				bus.alu_in_1 = imm_sext;
				bus.mem_op   = cpu_isa_pkg::mem_stw;   // data from rb, no reg write
			end
			// call writes pc+4 to r31, target in ra
			cpu_isa_pkg::op_call: begin
				bus.gpr_mux_ex = cpu_isa_pkg::ex_sel_link;
				bus.dst_addr   = cpu_isa_pkg::gpr_link_addr;
				bus.gpr_we     = 1'b1;
			end
			default: begin
				bus = cpu_pipe_pkg::id_ex_bubble;   // nop and undefined
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/id_reg.sv
/*
 * ID/EX pipeline register. Stall holds, flush loads a bubble,
 * otherwise the decoded bus and the fetch valid move on.
 */
`timescale 1ns/100ps
`default_nettype none

module id_reg (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     if_en,   // fetch valid
	input  wire logic                     stall,
	input  wire logic                     flush,
	input  wire cpu_pipe_pkg::id_ex_bus_t bus,     // from decoder
	output logic                          id_en,
	output cpu_pipe_pkg::id_ex_bus_t      id_ex
);

	// ----------------------------------------
	// stage register
	// priority: reset, stall, flush, load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_en <= 1'b0;
			id_ex <= cpu_pipe_pkg::id_ex_bubble;
		end else if (!stall) begin
			if (flush) begin
				id_en <= 1'b0;                          // kill the slot
				id_ex <= cpu_pipe_pkg::id_ex_bubble;    // same as reset
			end else begin
				id_en <= if_en;
				id_ex <= bus;
			end
		end
		// stall high: hold everything, flush ignored
	end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
/*
 * Instruction-decode stage. Register file, decoder and the ID/EX
 * stage register, one cycle from fetch inputs to execute outputs.
 */
`timescale 1ns/100ps
`default_nettype none

module id_stage (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 if_en,
	input  wire cpu_isa_pkg::word_t   insn,
	input  wire cpu_isa_pkg::word_t   pc,
	input  wire cpu_pipe_pkg::wb_t    wb,      // write-back strobe
	input  wire logic                 stall,
	input  wire logic                 flush,
	output logic                      id_en,
	output cpu_pipe_pkg::id_ex_bus_t  id_ex
);

	// ----------------------------------------
	// internal nets
	cpu_isa_pkg::reg_addr_t   ra_addr;
	cpu_isa_pkg::reg_addr_t   rb_addr;
	cpu_isa_pkg::word_t       ra_data;
	cpu_isa_pkg::word_t       rb_data;
	cpu_pipe_pkg::id_ex_bus_t dec_bus;   // decoder out, reg in

	gpr_file gpr_file_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.wb      (wb)
	);

	id_decoder id_decoder_inst (
		.insn    (insn),
		.pc      (pc),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.bus     (dec_bus)
	);

	id_reg id_reg_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.if_en (if_en),
		.stall (stall),
		.flush (flush),
		.bus   (dec_bus),
		.id_en (id_en),
		.id_ex (id_ex)
	);

endmodule

`default_nettype wire

// File: dv/id_stage_sva.sv
/*
 * Assertions on the ID/EX stage register. Reset state,
 * stall hold, flush bubble and a known bus after reset.
 */
`timescale 1ns/100ps
`default_nettype none

module id_stage_sva (
	input wire logic                     clk,
	input wire logic                     rst_n,
	input wire logic                     stall,
	input wire logic                     flush,
	input wire logic                     id_en,
	input wire cpu_pipe_pkg::id_ex_bus_t id_ex
);

	logic loaded;   // an unstalled edge seen since reset

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			loaded <= 1'b0;
		else if (!stall)
			loaded <= 1'b1;
	end

	// ----------------------------------------
	// stage register rules
	reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!loaded |-> !id_en)
		else $error("id_en set before the first unstalled edge");

	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(id_en) && $stable(id_ex))
		else $error("stage register changed during stall");

	flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		flush && !stall |=> !id_en && (id_ex == cpu_pipe_pkg::id_ex_bubble))
		else $error("flush did not load the bubble");

	bus_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(id_ex))
		else $error("id_ex has unknown bits");   // x after reset

endmodule

bind id_reg id_stage_sva id_stage_sva_inst (
	.clk   (clk),
	.rst_n (rst_n),
	.stall (stall),
	.flush (flush),
	.id_en (id_en),
	.id_ex (id_ex)
);

`default_nettype wire

// File: dv/id_stage_tb.sv
/*
 * Testbench for the instruction-decode stage. Replays the golden
 * file one line per cycle, drives fetch and write-back inputs and
 * compares id_en and every ID/EX bus field after the capture edge.
 */
`timescale 1ns/100ps
`default_nettype none

module id_stage_tb;

	localparam int    clk_period    = 20;
	localparam int    drive_delay   = 1;    // after the rising edge
	localparam int    reset_cycles  = 4;
	localparam int    reset_timeout = 20;
	localparam int    min_checks    = 20;
	localparam string golden_path   = "dv/id_stage_golden.txt";

	logic                     clk;
	logic                     rst_n;
	logic                     if_en;
	cpu_isa_pkg::word_t       insn;
	cpu_isa_pkg::word_t       pc;
	cpu_pipe_pkg::wb_t        wb;
	logic                     stall;
	logic                     flush;
	logic                     id_en;
	cpu_pipe_pkg::id_ex_bus_t id_ex;

	// expected outputs of the line driven one cycle earlier
	logic                     pend_valid;
	logic                     pend_en;
	cpu_pipe_pkg::id_ex_bus_t pend_bus;
	int                       checks_done;

	id_stage id_stage_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.if_en (if_en),
		.insn  (insn),
		.pc    (pc),
		.wb    (wb),
		.stall (stall),
		.flush (flush),
		.id_en (id_en),
		.id_ex (id_ex)
	);

	always #(clk_period / 2) clk = ~clk;

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#(drive_delay) rst_n = 1'b1;
	end

	// ----------------------------------------
	// reporting and compare tasks
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		abort_run($sformatf("Fail %0t %s expected %h actual %h", $time, name, exp_val, act_val));
	endtask

	task automatic check_en(input logic exp_en, input logic act_en);
		if (act_en !== exp_en)
			report_mismatch("id_en", 32'(exp_en), 32'(act_en));
	endtask

	task automatic check_bus(input cpu_pipe_pkg::id_ex_bus_t exp_bus,
			input cpu_pipe_pkg::id_ex_bus_t act_bus);
		if (act_bus.alu_op !== exp_bus.alu_op)
			report_mismatch("id_ex.alu_op", 32'(exp_bus.alu_op), 32'(act_bus.alu_op));
		if (act_bus.alu_in_0 !== exp_bus.alu_in_0)
			report_mismatch("id_ex.alu_in_0", exp_bus.alu_in_0, act_bus.alu_in_0);
		if (act_bus.alu_in_1 !== exp_bus.alu_in_1)
			report_mismatch("id_ex.alu_in_1", exp_bus.alu_in_1, act_bus.alu_in_1);
		if (act_bus.mem_op !== exp_bus.mem_op)
			report_mismatch("id_ex.mem_op", 32'(exp_bus.mem_op), 32'(act_bus.mem_op));
		if (act_bus.mem_wr_data !== exp_bus.mem_wr_data)
			report_mismatch("id_ex.mem_wr_data", exp_bus.mem_wr_data, act_bus.mem_wr_data);
		if (act_bus.dst_addr !== exp_bus.dst_addr)
			report_mismatch("id_ex.dst_addr", 32'(exp_bus.dst_addr), 32'(act_bus.dst_addr));
		if (act_bus.gpr_we !== exp_bus.gpr_we)
			report_mismatch("id_ex.gpr_we", 32'(exp_bus.gpr_we), 32'(act_bus.gpr_we));
		if (act_bus.gpr_mux_ex !== exp_bus.gpr_mux_ex)
			report_mismatch("id_ex.gpr_mux_ex", 32'(exp_bus.gpr_mux_ex),
				32'(act_bus.gpr_mux_ex));
		if (act_bus.gpr_mux_mem !== exp_bus.gpr_mux_mem)
			report_mismatch("id_ex.gpr_mux_mem", 32'(exp_bus.gpr_mux_mem),
				32'(act_bus.gpr_mux_mem));
		if (act_bus.gpr_wr_data !== exp_bus.gpr_wr_data)
			report_mismatch("id_ex.gpr_wr_data", exp_bus.gpr_wr_data, act_bus.gpr_wr_data);
	endtask

	// ----------------------------------------
	// one clock: drive after the edge, check previous line before the next edge
	task automatic run_cycle(input logic en_in, input cpu_isa_pkg::word_t insn_in,
			input cpu_isa_pkg::word_t pc_in, input logic stall_in, input logic flush_in,
			input cpu_pipe_pkg::wb_t wb_in, input logic exp_valid, input logic exp_en,
			input cpu_pipe_pkg::id_ex_bus_t exp_bus);
		@(posedge clk);
		#(drive_delay);
		if_en = en_in;
		insn  = insn_in;
		pc    = pc_in;
		stall = stall_in;
		flush = flush_in;
		wb    = wb_in;
		#(clk_period - 2 * drive_delay);   // outputs settled since last edge
		if (pend_valid) begin
			check_en(pend_en, id_en);
			check_bus(pend_bus, id_ex);
			checks_done++;
		end
		pend_valid = exp_valid;
		pend_en    = exp_en;
		pend_bus   = exp_bus;
	endtask

	initial begin
		int                       fd;
		int                       n;
		int                       line_no;
		int                       wait_cycles;
		string                    line;
		byte                      kind;
		logic [31:0]              f [0:19];
		logic [31:0]              w_addr;
		logic [31:0]              w_data;
		cpu_isa_pkg::word_t       insn_s;
		cpu_isa_pkg::word_t       pc_s;
		cpu_pipe_pkg::wb_t        wb_s;
		cpu_pipe_pkg::id_ex_bus_t exp_s;

		void'($urandom(32'h5ce9_8065));   // seeds the run
		if_en       = 1'b0;
		insn        = '0;
		pc          = '0;
		wb          = '0;
		stall       = 1'b0;
		flush       = 1'b0;
		pend_valid  = 1'b0;
		pend_en     = 1'b0;
		pend_bus    = cpu_pipe_pkg::id_ex_bubble;
		checks_done = 0;
		line_no     = 0;

		// wait for reset release, polled on falling edges
		wait_cycles = 0;
		while (rst_n !== 1'b1) begin
			if (wait_cycles >= reset_timeout) begin
				abort_run("reset was not released within 20 cycles");
			end else begin
				@(negedge clk);
				wait_cycles++;
			end
		end
		check_en(1'b0, id_en);   // no rising edge since release, reset value
		check_bus(cpu_pipe_pkg::id_ex_bubble, id_ex);

		fd = $fopen(golden_path, "r");
		if (fd == 0)
			abort_run("cannot open the golden file dv/id_stage_golden.txt");

		// ----------------------------------------
		// replay the file
		while ($fgets(line, fd) != 0) begin
			line_no++;
			kind = (line.len() > 0) ? line.getc(0) : 8'h00;
			if (line.len() < 2 || kind == "#") begin
				// comment or blank
			end else if (kind == "W") begin
				n = $sscanf(line, "W %h %h", w_addr, w_data);
				if (n != 2)
					abort_run($sformatf("malformed write-back line %0d in golden file", line_no));
				wb_s.en   = 1'b1;
				wb_s.addr = w_addr[4:0];
				wb_s.data = w_data;
				run_cycle(1'b0, '0, '0, 1'b0, 1'b0, wb_s, 1'b0, 1'b0,
					cpu_pipe_pkg::id_ex_bubble);
			end else if (kind == "C") begin
				n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
					f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
				if (n != 20)
					abort_run($sformatf("short or malformed line %0d in golden file", line_no));
				insn_s = f[1];
				pc_s   = f[2];
				if (f[8][0]) begin
					insn_s = $urandom;   // don't-care cycle
					pc_s   = $urandom;
				end
				wb_s.en           = f[5][0];
				wb_s.addr         = f[6][4:0];
				wb_s.data         = f[7];
				exp_s.alu_op      = cpu_isa_pkg::alu_op_t'(f[10][3:0]);
				exp_s.alu_in_0    = f[11];
				exp_s.alu_in_1    = f[12];
				exp_s.mem_op      = cpu_isa_pkg::mem_op_t'(f[13][1:0]);
				exp_s.mem_wr_data = f[14];
				exp_s.dst_addr    = f[15][4:0];
				exp_s.gpr_we      = f[16][0];
				exp_s.gpr_mux_ex  = cpu_isa_pkg::ex_out_sel_t'(f[17][0]);
				exp_s.gpr_mux_mem = f[18][0];
				exp_s.gpr_wr_data = f[19];
				run_cycle(f[0][0], insn_s, pc_s, f[3][0], f[4][0], wb_s, 1'b1, f[9][0], exp_s);
			end else begin
				abort_run($sformatf("unknown line type on line %0d of golden file", line_no));
			end
		end
		$fclose(fd);

		// idle cycle to check the last line
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, cpu_pipe_pkg::id_ex_bubble);

		if (checks_done < min_checks) begin
			abort_run($sformatf("golden file too short, only %0d lines checked", checks_done));
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src.f
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/gpr_file.sv
verilog/id_decoder.sv
verilog/id_reg.sv
verilog/id_stage.sv
dv/id_stage_sva.sv
dv/id_stage_tb.sv

// File: Makefile
# Verilator build and run for the instruction-decode stage testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = id_stage_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/id_stage_golden.txt
# C: if_en insn pc stall flush wb_en wb_addr wb_data dc | id_en alu_op alu_in_0 alu_in_1
#    mem_op mem_wr_data dst_addr gpr_we gpr_mux_ex gpr_mux_mem gpr_wr_data ; W: wb_addr wb_data
W 01 000000f0
W 02 00000f0f
W 03 fffffff0
W 04 10000000
W 00 deadbeef
# nop and undefined opcode
C 1 00000000 00001000 0 0 0 00 00000000 0 1 0 00000000 00000000 0 00000000 00 0 0 0 00000000
C 1 fc220000 00001004 0 0 0 00 00000000 0 1 0 00000000 00000000 0 00000000 00 0 0 0 00000000
# register-register and immediate ops
C 1 04222800 00001008 0 0 0 00 00000000 0 1 1 000000f0 00000f0f 0 00000f0f 05 1 0 0 0000100c
C 1 0c643000 0000100c 0 0 0 00 00000000 0 1 2 fffffff0 10000000 0 10000000 06 1 0 0 00001010
C 1 24813800 00001010 0 0 0 00 00000000 0 1 5 10000000 000000f0 0 000000f0 07 1 0 0 00001014
C 1 2c414000 00001014 0 0 0 00 00000000 0 1 7 00000f0f 000000f0 0 000000f0 08 1 0 0 00001018
C 1 08698001 00001018 0 0 0 00 00000000 0 1 1 fffffff0 00008001 0 00000000 09 1 0 0 0000101c
C 1 1022ff00 0000101c 0 0 0 00 00000000 0 1 2 000000f0 0000ff00 0 00000f0f 02 1 0 0 00001020
C 1 184affff 00001020 0 0 0 00 00000000 0 1 3 00000f0f 0000ffff 0 00000000 0a 1 0 0 00001024
C 1 202bfff8 00001024 0 0 0 00 00000000 0 1 4 000000f0 fffffff8 0 00000000 0b 1 0 0 00001028
# load, store, call
C 1 408c0010 00001028 0 0 0 00 00000000 0 1 4 10000000 00000010 1 00000000 0c 1 0 1 0000102c
C 1 4482fffc 0000102c 0 0 0 00 00000000 0 1 4 10000000 fffffffc 2 00000f0f 00 0 0 0 00001030
C 1 80200000 00001030 0 0 0 00 00000000 0 1 0 000000f0 00000000 0 00000000 1f 1 1 0 00001034
# r0 stays zero, write-back forwarding
C 1 1c006800 00001034 0 0 1 00 12345678 0 1 4 00000000 00000000 0 00000000 0d 1 0 0 00001038
C 1 14a17000 00001038 0 0 1 05 a5a5a5a5 0 1 3 a5a5a5a5 000000f0 0 000000f0 0e 1 0 0 0000103c
C 1 28267800 0000103c 0 0 1 06 00000004 0 1 6 000000f0 00000004 0 00000004 0f 1 0 0 00001040
# stall, stall with flush, flush, resume
C 1 1ca68000 00001040 0 0 0 00 00000000 0 1 4 a5a5a5a5 00000004 0 00000004 10 1 0 0 00001044
C 1 00000000 00000000 1 0 0 00 00000000 1 1 4 a5a5a5a5 00000004 0 00000004 10 1 0 0 00001044
C 1 00000000 00000000 1 1 0 00 00000000 1 1 4 a5a5a5a5 00000004 0 00000004 10 1 0 0 00001044
C 1 00000000 00000000 0 1 0 00 00000000 1 0 0 00000000 00000000 0 00000000 00 0 0 0 00000000
C 1 24a68800 00001044 0 0 0 00 00000000 0 1 5 a5a5a5a5 00000004 0 00000004 11 1 0 0 00001048
C 0 00000000 00000000 1 0 0 00 00000000 1 1 5 a5a5a5a5 00000004 0 00000004 11 1 0 0 00001048
C 0 10030001 00001048 0 0 0 00 00000000 0 0 2 00000000 00000001 0 fffffff0 03 1 0 0 0000104c
C 1 00000000 0000104c 0 0 0 00 00000000 0 1 0 00000000 00000000 0 00000000 00 0 0 0 00000000
